/* div_array_top.sv */
`timescale 1ns/1ps
`default_nettype none

`include "div_params.svh"

module div_array_top (
    input  logic              clk,
    input  logic              reset,
    input  logic              in_valid,
    input  div_pkg::div_req_t in_req,
    output logic              full,
    output logic              out_valid,
    output div_pkg::div_rsp_t out_rsp
);

    import div_pkg::*;

    // dispatcher to lanes
    logic [`DIV_LANES-1:0]     lane_start;
    div_req_t                  lane_req;

    // lane status and results
    logic [`DIV_LANES-1:0]     lane_busy;
    logic [`DIV_LANES-1:0]     lane_result_valid;
    div_rsp_t [`DIV_LANES-1:0] lane_rsp;

    // collector to lanes
    logic [`DIV_LANES-1:0]     lane_take;

    div_dispatch i_div_dispatch (
        .clk        (clk),
        .reset      (reset),
        .in_valid   (in_valid),
        .in_req     (in_req),
        .lane_busy  (lane_busy),
        .lane_start (lane_start),
        .lane_req   (lane_req),
        .full       (full)
    );

    for (genvar g = 0; g < `DIV_LANES; g++) begin : g_lane
        div_lane i_div_lane (
            .clk          (clk),
            .reset        (reset),
            .start        (lane_start[g]),
            .req          (lane_req),
            .take         (lane_take[g]),
            .busy         (lane_busy[g]),
            .result_valid (lane_result_valid[g]),
            .rsp          (lane_rsp[g])
        );
    end

    // drains lanes in issue order
    div_collect i_div_collect (
        .clk               (clk),
        .reset             (reset),
        .lane_result_valid (lane_result_valid),
        .lane_rsp          (lane_rsp),
        .lane_take         (lane_take),
        .out_valid         (out_valid),
        .out_rsp           (out_rsp)
    );

endmodule

`default_nettype wire

/* div_collect.sv */
`timescale 1ns/1ps
`default_nettype none

`include "div_params.svh"

module div_collect (
    input  logic                                  clk,
    input  logic                                  reset,
    input  logic [`DIV_LANES-1:0]                 lane_result_valid,
    input  div_pkg::div_rsp_t [`DIV_LANES-1:0]    lane_rsp,
    output logic [`DIV_LANES-1:0]                 lane_take,
    output logic                                  out_valid,
    output div_pkg::div_rsp_t                     out_rsp
);

    import div_pkg::*;

    lane_idx_t drain_ptr;
    logic      take_now;

    // only the lane at the drain pointer may hand over its result
    assign take_now = lane_result_valid[drain_ptr];

    always_comb begin
        lane_take            = '0;
        lane_take[drain_ptr] = take_now;
    end

    // drain pointer and output strobe
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            drain_ptr <= '0;
            out_valid <= 1'b0;
        end else begin
            out_valid <= take_now;
            if (take_now) begin
                if (drain_ptr == lane_idx_t'(`DIV_LANES - 1)) begin
                    drain_ptr <= '0;
                end else begin
                    drain_ptr <= drain_ptr + lane_idx_t'(1);
                end
            end
        end
    end

    // result register
    always_ff @(posedge clk) begin
        if (take_now) begin
            out_rsp <= lane_rsp[drain_ptr];
        end
    end

endmodule

`default_nettype wire

/* div_dispatch.sv */
`timescale 1ns/1ps
`default_nettype none

`include "div_params.svh"

module div_dispatch (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  in_valid,
    input  div_pkg::div_req_t     in_req,
    input  logic [`DIV_LANES-1:0] lane_busy,
    output logic [`DIV_LANES-1:0] lane_start,
    output div_pkg::div_req_t     lane_req,
    output logic                  full
);

    import div_pkg::*;

    lane_idx_t issue_ptr;
    logic      accept;

    // the next lane in order is still occupied
    assign full   = lane_busy[issue_ptr];
    assign accept = in_valid && !full;

    // every lane sees the request, only the addressed one starts
    assign lane_req = in_req;

    always_comb begin
        lane_start            = '0;
        lane_start[issue_ptr] = accept;
    end

    // round-robin issue pointer
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            issue_ptr <= '0;
        end else if (accept) begin
            if (issue_ptr == lane_idx_t'(`DIV_LANES - 1)) begin
                issue_ptr <= '0;
            end else begin
                issue_ptr <= issue_ptr + lane_idx_t'(1);
            end
        end
    end

endmodule

`default_nettype wire

/* div_lane.sv */
`timescale 1ns/1ps
`default_nettype none

`include "div_params.svh"

module div_lane (
    input  logic              clk,
    input  logic              reset,
    input  logic              start,
    input  div_pkg::div_req_t req,
    input  logic              take,
    output logic              busy,
    output logic              result_valid,
    output div_pkg::div_rsp_t rsp
);

    import div_pkg::*;

    localparam int W = `DIV_DIVIDEND_WIDTH;

    lane_state_t  state;

    // working registers of one division
    logic [W-1:0] rem;
    divisor_t     divisor;
    logic [W-1:0] quot;
    logic         neg;

    // per-step shift and subtrahend
    bit_pos_t     rem_msb;
    bit_pos_t     div_msb;
    bit_pos_t     shift;
    logic [W-1:0] div_ext;
    logic [W-1:0] div_shifted;
    logic [W-1:0] step;
    logic         done;

    // position of the highest set bit, zero for an all-zero vector
    function automatic bit_pos_t leading_one(input logic [W-1:0] v);
        bit_pos_t pos;
        pos = '0;
        for (int i = 0; i < W; i++) begin
            if (v[i]) begin
                pos = bit_pos_t'(i);
            end
        end
        return pos;
    endfunction

    // 16-bit negation wraps, so -32768 maps back onto itself
    function automatic dividend_t apply_sign(input logic [W-1:0] mag, input logic negative);
        logic [W-1:0] result;
        result = negative ? -mag : mag;
        return dividend_t'(result);
    endfunction

    always_comb begin
        div_ext = W'(divisor);
        rem_msb = leading_one(rem);
        div_msb = leading_one(div_ext);
        shift   = rem_msb - div_msb;
        // aligned divisor may still exceed the remainder by one position
        if ((div_ext << shift) > rem) begin
            shift = shift - bit_pos_t'(1);
        end
        div_shifted = div_ext << shift;
        step        = W'(1) << shift;
        done        = (rem < div_ext);
    end

    // control FSM
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state <= IDLE;
        end else begin
            case (state)
                IDLE: begin
                    if (start) begin
                        state <= (req.divisor <= divisor_t'(1)) ? PASS : LOOP;
                    end
                end
                PASS: begin
                    state <= HOLD;
                end
                LOOP: begin
                    if (done) begin
                        state <= HOLD;
                    end
                end
                HOLD: begin
                    if (take) begin
                        state <= IDLE;
                    end
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

    // datapath
    always_ff @(posedge clk) begin
        case (state)
            IDLE: begin
                if (start) begin
                    rem     <= req.dividend[W-1] ? -req.dividend : req.dividend;
                    neg     <= req.dividend[W-1];
                    divisor <= req.divisor;
                    quot    <= '0;
                end
            end
            PASS: begin
                // sign on the magnitude gives back the dividend
                rsp.quotient <= apply_sign(rem, neg);
            end
            LOOP: begin
                if (done) begin
                    rsp.quotient <= apply_sign(quot, neg);
                end else begin
                    rem  <= rem - div_shifted;
                    quot <= quot + step;
                end
            end
            default: begin
                // HOLD keeps the result for the collector
            end
        endcase
    end

    assign busy         = (state != IDLE);
    assign result_valid = (state == HOLD);

endmodule

`default_nettype wire

/* div_params.svh */
`ifndef DIV_PARAMS_SVH
`define DIV_PARAMS_SVH

// width of the signed dividend and of the quotient
`define DIV_DIVIDEND_WIDTH 16

// width of the unsigned divisor
`define DIV_DIVISOR_WIDTH 8

// number of divider lanes behind the dispatcher
// 2, 4 or 8 lanes are supported
`define DIV_LANES 4

`endif

/* div_pkg.sv */
`default_nettype none

`include "div_params.svh"

package div_pkg;

    // operand and result vectors
    typedef logic signed [`DIV_DIVIDEND_WIDTH-1:0] dividend_t;
    typedef dividend_t quotient_t;
    typedef logic [`DIV_DIVISOR_WIDTH-1:0] divisor_t;

    // bit index inside a dividend
    typedef logic [$clog2(`DIV_DIVIDEND_WIDTH)-1:0] bit_pos_t;

    // lane number for the issue and drain pointers
    typedef logic [$clog2(`DIV_LANES)-1:0] lane_idx_t;

    // one division request
    typedef struct packed {
        dividend_t dividend;
        divisor_t  divisor;
    } div_req_t;

    // one division result
    typedef struct packed {
        quotient_t quotient;
    } div_rsp_t;

    // lane FSM states
    typedef enum logic [1:0] {IDLE, PASS, LOOP, HOLD} lane_state_t;

endpackage

`default_nettype wire

/* filelist.f */
+incdir+.
div_pkg.sv
div_lane.sv
div_dispatch.sv
div_collect.sv
div_array_top.sv
tb_div_array.sv

/* run_sim.sh */
#!/bin/sh
# build and run the divider array testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
TOP=tb_div_array

verilator --binary --timing \
    -f filelist.f \
    --top-module "$TOP" \
    --Mdir obj_dir \
    -o "$TOP"
status=$?
if [ "$status" -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit 1
fi

./obj_dir/"$TOP" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ "$status" -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q -x ">>> PASS" "$LOG"; then
    echo "simulation passed"
    exit 0
else
    echo "simulation failed, see $LOG"
    exit 1
fi

/* tb_div_array.sv */
`timescale 1ns/1ps
`default_nettype none

`include "div_params.svh"

module tb_div_array;

    import div_pkg::*;

    localparam int W            = `DIV_DIVIDEND_WIDTH;
    localparam int WAIT_LIMIT   = 200;
    localparam int DRAIN_LIMIT  = 2000;
    localparam int RANDOM_COUNT = 300;

    logic     clk;
    logic     reset;
    logic     in_valid;
    div_req_t in_req;
    logic     full;
    logic     out_valid;
    div_rsp_t out_rsp;

    // expected quotients in issue order
    quotient_t expected_q[$];

    int seed;
    int accepted_count = 0;
    int result_count   = 0;
    int value_errors   = 0;
    int full_errors    = 0;
    int count_errors   = 0;
    int stray_errors   = 0;
    int timeout_errors = 0;

    div_array_top i_div_array_top (
        .clk       (clk),
        .reset     (reset),
        .in_valid  (in_valid),
        .in_req    (in_req),
        .full      (full),
        .out_valid (out_valid),
        .out_rsp   (out_rsp)
    );

    always #5 clk = ~clk;

    // truncating division, sign follows the dividend, 16-bit wrap on negation
    function automatic quotient_t ref_quotient(input dividend_t dividend, input divisor_t divisor);
        logic [W-1:0] mag;
        logic [W-1:0] q;
        if (divisor < divisor_t'(2)) begin
            return dividend;
        end
        mag = W'(dividend);
        if (dividend[W-1]) begin
            mag = W'(0) - mag;
        end
        q = mag / W'(divisor);
        if (dividend[W-1]) begin
            q = W'(0) - q;
        end
        return quotient_t'(q);
    endfunction

    task automatic check_quotient(input quotient_t expected, input quotient_t actual);
        if (actual !== expected) begin
            value_errors++;
            $display("[ERROR] %0t out_rsp.quotient expected %0d actual %0d",
                     $time, expected, actual);
        end
    endtask

    task automatic check_full(input logic expected);
        if (full !== expected) begin
            full_errors++;
            $display("[ERROR] %0t full expected %0b actual %0b", $time, expected, full);
        end
    endtask

    task automatic check_count(input int expected, input int actual);
        if (actual != expected) begin
            count_errors++;
            $display("[ERROR] %0t result_count expected %0d actual %0d", $time, expected, actual);
        end
    endtask

    task automatic finish_run();
        int total;
        total = value_errors + full_errors + count_errors + stray_errors + timeout_errors;
        $display("errors: value %0d, full %0d, count %0d, stray %0d, timeout %0d (%0d results)",
                 value_errors, full_errors, count_errors, stray_errors, timeout_errors,
                 result_count);
        if (total == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    endtask

    task automatic abort_timeout(input string what);
        timeout_errors++;
        $display("timeout at %0t: %s", $time, what);
        finish_run();
    endtask

    // one strobe, issued once the lane at the issue pointer is free
    task automatic send_req(input dividend_t dividend, input divisor_t divisor);
        int n;
        n = 0;
        while (full) begin
            @(posedge clk);
            #1;
            n++;
            if (n > WAIT_LIMIT) begin
                abort_timeout("full stayed high while a request was waiting");
            end
        end
        in_valid        = 1'b1;
        in_req.dividend = dividend;
        in_req.divisor  = divisor;
        expected_q.push_back(ref_quotient(dividend, divisor));
        accepted_count++;
        @(posedge clk);
        #1;
        in_valid = 1'b0;
    endtask

    task automatic wait_drain();
        int n;
        n = 0;
        while (expected_q.size() != 0) begin
            @(posedge clk);
            #1;
            n++;
            if (n > DRAIN_LIMIT) begin
                abort_timeout("results still outstanding after the drain limit");
            end
        end
    endtask

    // compare on the falling edge, where out_valid and out_rsp are settled
    always @(negedge clk) begin
        if (!reset && out_valid) begin
            if (expected_q.size() == 0) begin
                stray_errors++;
                $display("output at %0t arrived with no request outstanding", $time);
            end else begin
                check_quotient(expected_q.pop_front(), out_rsp.quotient);
            end
            result_count++;
        end
    end

    initial begin
        logic [31:0] r;
        dividend_t   rnd_dividend;
        divisor_t    rnd_divisor;
        seed     = 32'h9593;
        clk      = 1'b0;
        reset    = 1'b1;
        in_valid = 1'b0;
        in_req   = '0;
        repeat (16) @(posedge clk);
        #1;
        reset = 1'b0;

        // quiet after reset, any output here is a stray
        check_full(1'b0);
        repeat (20) @(posedge clk);
        #1;
        check_full(1'b0);

        // divisor 0 and 1 pass the dividend through
        for (int d = 0; d < 2; d++) begin
            send_req(16'sd1234, divisor_t'(d));
            send_req(-16'sd1234, divisor_t'(d));
            send_req(16'sd0, divisor_t'(d));
            send_req(16'sh8000, divisor_t'(d));
            send_req(16'sd32767, divisor_t'(d));
        end
        wait_drain();

        // directed extremes
        send_req(16'sd32767, 8'd255);
        send_req(16'sh8000, 8'd2);
        send_req(-16'sd1, 8'd3);
        send_req(16'sd5, 8'd7);
        send_req(16'sd255, 8'd255);
        wait_drain();

        // long operands back to back, the oldest lane is still busy afterwards
        for (int i = 0; i < `DIV_LANES; i++) begin
            send_req(dividend_t'(32767 - 2 * i), 8'd2);
        end
        check_full(1'b1);
        for (int i = 0; i < `DIV_LANES; i++) begin
            send_req(dividend_t'(-32767 + 3 * i), 8'd3);
        end
        wait_drain();

        // random mix of pass-through, short and long divisions
        for (int i = 0; i < RANDOM_COUNT; i++) begin
            r            = $random(seed);
            rnd_dividend = dividend_t'(r[15:0]);
            if (r[26:24] == 3'd0) begin
                rnd_divisor = divisor_t'(r[27]);
            end else if (r[26:24] == 3'd1) begin
                rnd_divisor = divisor_t'(r[17:16]) + divisor_t'(2);
            end else begin
                rnd_divisor = r[23:16];
            end
            send_req(rnd_dividend, rnd_divisor);
            if (r[31:30] == 2'd0) begin
                @(posedge clk);
                #1;
            end
        end
        wait_drain();
        repeat (5) @(posedge clk);
        #1;
        check_count(accepted_count, result_count);
        finish_run();
    end

endmodule

`default_nettype wire
